// ==== hdl/layerRegs.sv ====
`timescale 1ns/1ns

module layerRegs import tilePkg::*; #(
	parameter int NUM_LAYERS = 2
) (
	input logic CLK_6M,
	input logic arstN,
	// Write address and data channels
	input logic awvalid,
	output logic awready,
	input axiAddrT awaddr,
	input logic wvalid,
	output logic wready,
	input axiDataT wdata,
	// Write response channel
	output logic bvalid,
	input logic bready,
	output axiRespT bresp,
	// Read address channel
	input logic arvalid,
	output logic arready,
	input axiAddrT araddr,
	// Read data channel
	output logic rvalid,
	input logic rready,
	output axiDataT rdata,
	output axiRespT rresp,
	// Per-layer settings
	output prioT [NUM_LAYERS-1:0] layerPrio,
	output logic [NUM_LAYERS-1:0] layerFlip
);

	regStateT state;

	// Address decode results
	logic [NUM_LAYERS-1:0] writeSel;
	logic writeOk;
	logic readOk;
	logic [3:0] readVal;

	// Handshake strobes
	logic acceptWrite;
	logic acceptRead;

	////////////////////
	// Handshake
	////////////////////

	// Address and data only together, and only when idle
	assign acceptWrite = (state == idle) && awvalid && wvalid;
	// Write goes first when both are offered
	assign acceptRead = (state == idle) && arvalid && !(awvalid && wvalid);

	assign awready = acceptWrite;
	assign wready = acceptWrite;
	assign arready = acceptRead;

	assign bvalid = (state == writeResp);
	assign rvalid = (state == readResp);

	////////////////////
	// Address decode
	////////////////////

	// One word per layer, anything else misses every slot
	always_comb begin
		writeSel = '0;
		readOk = 1'b0;
		readVal = 4'b0;
		for (int n = 0; n < NUM_LAYERS; n++) begin
			if (awaddr[1:0] == 2'b00 && awaddr[7:2] == 6'(n)) begin
				writeSel[n] = 1'b1;
			end
			if (araddr[1:0] == 2'b00 && araddr[7:2] == 6'(n)) begin
				readOk = 1'b1;
				readVal = {layerFlip[n], layerPrio[n]};
			end
		end
	end

	assign writeOk = |writeSel;

	////////////////////
	// FSM and registers
	////////////////////

	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			state <= idle;
			layerPrio <= '0;
			layerFlip <= '0;
		end else begin
			case (state)
				idle: begin
					if (acceptWrite) begin
						state <= writeResp;
						// Bad address leaves every layer untouched
						for (int n = 0; n < NUM_LAYERS; n++) begin
							if (writeSel[n]) begin
								layerPrio[n] <= wdata[2:0];
								layerFlip[n] <= wdata[3];
							end
						end
					end else if (acceptRead) begin
						state <= readResp;
					end
				end
				// Hold response until the CPU takes it
				writeResp: if (bready) state <= idle;
				readResp: if (rready) state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// Response payload, only looked at while its valid is high
	always_ff @(posedge CLK_6M) begin
		if (acceptWrite) begin
			bresp <= writeOk ? RESP_OKAY : RESP_SLVERR;
		end
		if (acceptRead) begin
			rresp <= readOk ? RESP_OKAY : RESP_SLVERR;
			rdata <= {28'b0, readVal};
		end
	end

endmodule

// ==== hdl/layerShifter.sv ====
`timescale 1ns/1ns

module layerShifter import tilePkg::*; (
	input logic CLK_6M,
	input logic arstN,
	input logic load,
	input planeRowT row,
	input colorT color,
	input logic flip,
	output dotT dot,
	output colorT layerColor
);

	////////////////////
	// Plane shift registers
	////////////////////

	logic [3:0] plane0;
	logic [3:0] plane1;
	logic [3:0] plane2;

	// Direction in force for the current row
	logic flipRow;

	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			// All ones reads as transparent
			plane0 <= 4'hf;
			plane1 <= 4'hf;
			plane2 <= 4'hf;
			flipRow <= 1'b0;
			layerColor <= '0;
		end else if (load) begin
			plane0 <= row[3:0];
			plane1 <= row[7:4];
			plane2 <= row[11:8];
			// Sampled once so a row never turns around
			flipRow <= flip;
			layerColor <= color;
		end else if (flipRow) begin
			// Towards bit 0, ones come in from the top
			plane0 <= {1'b1, plane0[3:1]};
			plane1 <= {1'b1, plane1[3:1]};
			plane2 <= {1'b1, plane2[3:1]};
		end else begin
			// Towards bit 3, ones come in from the bottom
			plane0 <= {plane0[2:0], 1'b1};
			plane1 <= {plane1[2:0], 1'b1};
			plane2 <= {plane2[2:0], 1'b1};
		end
	end

	////////////////////
	// Dot output
	////////////////////

	// Normal order takes bit 3 first, flipped takes bit 0 first
	always_comb begin
		if (flipRow) begin
			dot = {plane2[0], plane1[0], plane0[0]};
		end else begin
			dot = {plane2[3], plane1[3], plane0[3]};
		end
	end

endmodule

// ==== hdl/priorityMixer.sv ====
`timescale 1ns/1ns

module priorityMixer import tilePkg::*; #(
	parameter int NUM_LAYERS = 2
) (
	input logic CLK_6M,
	input logic arstN,
	// Layer pixels, same cycle as the cascade
	input dotT [NUM_LAYERS-1:0] layerDot,
	input colorT [NUM_LAYERS-1:0] layerColor,
	input prioT [NUM_LAYERS-1:0] layerPrio,
	input logic rowStart,
	// Pixel from the earlier chip in the chain
	input prioT cascadePrio,
	input colorT cascadeColor,
	input dotT cascadeDot,
	// Chip pixel output
	output prioT pixPrio,
	output colorT pixColor,
	output dotT pixDot,
	output logic pixelStart
);

	prioT winPrio;
	colorT winColor;
	dotT winDot;

	// Cascade is the starting winner
	// A layer takes over only if opaque and strictly higher, so ties stay with the
	// earlier source
	always_comb begin
		winPrio = cascadePrio;
		winColor = cascadeColor;
		winDot = cascadeDot;
		for (int n = 0; n < NUM_LAYERS; n++) begin
			if (layerDot[n] != TRANSPARENT_DOT && layerPrio[n] > winPrio) begin
				winPrio = layerPrio[n];
				winColor = layerColor[n];
				winDot = layerDot[n];
			end
		end
	end

	// Output register, row marker moves with its pixel
	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			pixPrio <= '0;
			pixColor <= '0;
			pixDot <= '0;
			pixelStart <= 1'b0;
		end else begin
			pixPrio <= winPrio;
			pixColor <= winColor;
			pixDot <= winDot;
			pixelStart <= rowStart;
		end
	end

endmodule

// ==== hdl/tileLayers.sv ====
`timescale 1ns/1ns

module tileLayers import tilePkg::*; #(
	parameter int NUM_LAYERS = 2,
	localparam int LAYER_W = (NUM_LAYERS > 1) ? $clog2(NUM_LAYERS) : 1
) (
	input logic CLK_6M,
	input logic arstN,
	// CPU register port
	input logic awvalid,
	output logic awready,
	input axiAddrT awaddr,
	input logic wvalid,
	output logic wready,
	input axiDataT wdata,
	output logic bvalid,
	input logic bready,
	output axiRespT bresp,
	input logic arvalid,
	output logic arready,
	input axiAddrT araddr,
	output logic rvalid,
	input logic rready,
	output axiDataT rdata,
	output axiRespT rresp,
	// Tile fetch port
	input logic loadValid,
	output logic loadReady,
	input logic [LAYER_W-1:0] loadLayer,
	input planeRowT loadRow,
	input colorT loadColor,
	// Cascade in, pixel out
	input prioT cascadePrio,
	input colorT cascadeColor,
	input dotT cascadeDot,
	output prioT pixPrio,
	output colorT pixColor,
	output dotT pixDot,
	output logic pixelStart
);

	prioT [NUM_LAYERS-1:0] layerPrio;
	logic [NUM_LAYERS-1:0] layerFlip;

	// Sequencer to shifters
	logic [NUM_LAYERS-1:0] layerLoad;
	planeRowT [NUM_LAYERS-1:0] pendRow;
	colorT [NUM_LAYERS-1:0] pendColor;
	logic rowStart;

	// Shifters to mixer
	dotT [NUM_LAYERS-1:0] shiftDot;
	colorT [NUM_LAYERS-1:0] shiftColor;

	layerRegs #(.NUM_LAYERS(NUM_LAYERS)) i_layerRegs (
		.CLK_6M, .arstN,
		.awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
		.bvalid, .bready, .bresp,
		.arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
		.layerPrio, .layerFlip
	);

	tileLoadSequencer #(.NUM_LAYERS(NUM_LAYERS)) i_tileLoadSequencer (
		.CLK_6M, .arstN,
		.loadValid, .loadReady, .loadLayer, .loadRow, .loadColor,
		.layerLoad, .layerRow(pendRow), .layerColor(pendColor), .rowStart
	);

	////////////////////
	// Layer array
	////////////////////

	for (genvar g = 0; g < NUM_LAYERS; g++) begin : genLayer
		layerShifter i_layerShifter (
			.CLK_6M, .arstN,
			.load(layerLoad[g]), .row(pendRow[g]), .color(pendColor[g]), .flip(layerFlip[g]),
			.dot(shiftDot[g]), .layerColor(shiftColor[g])
		);
	end

	priorityMixer #(.NUM_LAYERS(NUM_LAYERS)) i_priorityMixer (
		.CLK_6M, .arstN,
		.layerDot(shiftDot), .layerColor(shiftColor), .layerPrio, .rowStart,
		.cascadePrio, .cascadeColor, .cascadeDot,
		.pixPrio, .pixColor, .pixDot, .pixelStart
	);

endmodule

// ==== hdl/tileLoadSequencer.sv ====
`timescale 1ns/1ns

module tileLoadSequencer import tilePkg::*; #(
	parameter int NUM_LAYERS = 2,
	localparam int LAYER_W = (NUM_LAYERS > 1) ? $clog2(NUM_LAYERS) : 1
) (
	input logic CLK_6M,
	input logic arstN,
	// Fetch side
	input logic loadValid,
	output logic loadReady,
	input logic [LAYER_W-1:0] loadLayer,
	input planeRowT loadRow,
	input colorT loadColor,
	// Towards the shifters
	output logic [NUM_LAYERS-1:0] layerLoad,
	output planeRowT [NUM_LAYERS-1:0] layerRow,
	output colorT [NUM_LAYERS-1:0] layerColor,
	output logic rowStart
);

	// Free-running pixel phase within a tile
	logic [1:0] phase;
	logic boundary;

	// One pending row per layer
	logic [NUM_LAYERS-1:0] slotFull;
	planeRowT [NUM_LAYERS-1:0] slotRow;
	colorT [NUM_LAYERS-1:0] slotColor;

	logic takeLoad;

	assign boundary = (phase == 2'(PIXELS_PER_ROW - 1));

	// Ready follows the addressed slot
	// An index past the last layer is never ready
	always_comb begin
		loadReady = 1'b0;
		for (int n = 0; n < NUM_LAYERS; n++) begin
			if (loadLayer == LAYER_W'(n)) loadReady = !slotFull[n];
		end
	end

	assign takeLoad = loadValid && loadReady;

	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			phase <= 2'd0;
			slotFull <= '0;
			rowStart <= 1'b0;
		end else begin
			phase <= phase + 2'd1;
			// High during the shifters' first pixel of the row
			rowStart <= boundary;
			for (int n = 0; n < NUM_LAYERS; n++) begin
				// Release first, a new load into the empty slot then refills it
				if (boundary) slotFull[n] <= 1'b0;
				if (takeLoad && loadLayer == LAYER_W'(n)) slotFull[n] <= 1'b1;
			end
		end
	end

	// Pending payload
	always_ff @(posedge CLK_6M) begin
		for (int n = 0; n < NUM_LAYERS; n++) begin
			if (takeLoad && loadLayer == LAYER_W'(n)) begin
				slotRow[n] <= loadRow;
				slotColor[n] <= loadColor;
			end
		end
	end

	// Strobe every full slot on the tile boundary
	assign layerLoad = slotFull & {NUM_LAYERS{boundary}};
	assign layerRow = slotRow;
	assign layerColor = slotColor;

endmodule

// ==== hdl/tilePkg.sv ====
package tilePkg;

	////////////////////
	// Pixel fields
	////////////////////

	// Layer or pixel priority, higher wins
	typedef logic [2:0] prioT;

	// Colour and palette byte carried with every tile row
	typedef logic [7:0] colorT;

	// One pixel, one bit per bitplane
	typedef logic [2:0] dotT;

	// Plane 0 in 3..0, plane 1 in 7..4, plane 2 in 11..8
	// Leftmost pixel of each plane is its bit 3
	typedef logic [11:0] planeRowT;

	////////////////////
	// CPU bus
	////////////////////

	typedef logic [7:0] axiAddrT;
	typedef logic [31:0] axiDataT;
	typedef logic [1:0] axiRespT;

	// Register block handshake states
	typedef enum logic [1:0] {
		idle,
		writeResp,
		readResp
	} regStateT;

	// All three planes set, never wins priority
	localparam dotT TRANSPARENT_DOT = 3'd7;

	// Pixels in one tile row
	localparam int PIXELS_PER_ROW = 4;

	localparam axiRespT RESP_OKAY = 2'b00;
	localparam axiRespT RESP_SLVERR = 2'b10;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build and run the tile layer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -f src.f --top-module tbTileLayers -o simTileLayers \
	&& ./obj_dir/simTileLayers | grep -q "SIMULATION PASSED" \
	&& echo "run.sh: pass" \
	|| { echo "run.sh: fail"; exit 1; }

// ==== src.f ====
hdl/tilePkg.sv
hdl/layerRegs.sv
hdl/tileLoadSequencer.sv
hdl/layerShifter.sv
hdl/priorityMixer.sv
hdl/tileLayers.sv
tb/tbTileLayers.sv

// ==== tb/tbTileLayers.sv ====
`timescale 1ns/1ns

module tbTileLayers import tilePkg::*;;

	logic CLK_6M;
	logic arstN;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	axiAddrT awaddr, araddr;
	axiDataT wdata, rdata;
	axiRespT bresp, rresp;
	logic loadValid, loadReady;
	logic [0:0] loadLayer;
	planeRowT loadRow;
	colorT loadColor;
	prioT cascadePrio, pixPrio;
	colorT cascadeColor, pixColor;
	dotT cascadeDot, pixDot;
	logic pixelStart;

	// Vector lines, read once before the run
	string lines[$];
	int fd;
	string text;
	string cmd;
	string name;
	logic [31:0] v[12];
	logic [31:0] lcgState;

	tileLayers #(.NUM_LAYERS(2)) i_tileLayers (.*);

	initial begin
		CLK_6M = 1'b0;
		forever #2 CLK_6M = ~CLK_6M;
	end

	////////////////////
	// Compare tasks
	////////////////////

	task automatic stopOnMismatch(string test, logic [31:0] exp, logic [31:0] act);
		$display("CHECK FAILED %s: expected %h, actual %h", test, exp, act);
		$display("SIMULATION FAILED");
		$fatal(1, "mismatch in %s", test);
	endtask

	task automatic checkPrio(string test, prioT exp, prioT act);
		if (act !== exp) stopOnMismatch(test, 32'(exp), 32'(act));
	endtask

	task automatic checkColor(string test, colorT exp, colorT act);
		if (act !== exp) stopOnMismatch(test, 32'(exp), 32'(act));
	endtask

	task automatic checkDot(string test, dotT exp, dotT act);
		if (act !== exp) stopOnMismatch(test, 32'(exp), 32'(act));
	endtask

	task automatic checkResp(string test, axiRespT exp, axiRespT act);
		if (act !== exp) stopOnMismatch(test, 32'(exp), 32'(act));
	endtask

	task automatic checkData(string test, axiDataT exp, axiDataT act);
		if (act !== exp) stopOnMismatch(test, exp, act);
	endtask

	// Numerical Recipes constants
	function automatic logic [31:0] lcgNext(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	////////////////////
	// Bus drivers
	////////////////////

	// Every driver starts and ends 1 ns after a rising edge
	task automatic busWrite(axiAddrT addr, axiDataT data, axiRespT exp);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		#1;
		// Address and data are taken in the same cycle
		while (!(awready && wready)) begin
			@(posedge CLK_6M);
			#2;
		end
		@(posedge CLK_6M);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		// Response shows up one cycle after the handshake
		while (!bvalid) begin
			@(posedge CLK_6M);
			#1;
		end
		checkResp($sformatf("write %h resp", addr), exp, bresp);
		@(posedge CLK_6M);
		#1;
	endtask

	task automatic busRead(axiAddrT addr, axiDataT expData, axiRespT exp);
		araddr = addr;
		arvalid = 1'b1;
		#1;
		while (!arready) begin
			@(posedge CLK_6M);
			#2;
		end
		@(posedge CLK_6M);
		#1;
		arvalid = 1'b0;
		while (!rvalid) begin
			@(posedge CLK_6M);
			#1;
		end
		checkResp($sformatf("read %h resp", addr), exp, rresp);
		checkData($sformatf("read %h data", addr), expData, rdata);
		@(posedge CLK_6M);
		#1;
	endtask

	task automatic tileLoad(logic [0:0] layer, planeRowT row, colorT color);
		loadLayer = layer;
		loadRow = row;
		loadColor = color;
		loadValid = 1'b1;
		#1;
		while (!loadReady) begin
			@(posedge CLK_6M);
			#2;
		end
		@(posedge CLK_6M);
		#1;
		loadValid = 1'b0;
	endtask

	// Slot still full, so the fetch side must be held off
	task automatic expectBusy(logic [0:0] layer);
		loadLayer = layer;
		loadValid = 1'b0;
		#1;
		if (loadReady) begin
			$display("loadReady is high for layer %0d although its slot is full", layer);
			$display("SIMULATION FAILED");
			$fatal(1, "back-pressure missing");
		end
		@(posedge CLK_6M);
		#1;
	endtask

	task automatic waitRowStart();
		while (!pixelStart) begin
			@(posedge CLK_6M);
			#1;
		end
	endtask

	// Four pixels from the next pixelStart on
	task automatic expectRow(string test);
		waitRowStart();
		for (int i = 0; i < PIXELS_PER_ROW; i++) begin
			if (i > 0) begin
				@(posedge CLK_6M);
				#1;
			end
			checkPrio($sformatf("%s px%0d prio", test, i), prioT'(v[3*i]), pixPrio);
			checkColor($sformatf("%s px%0d color", test, i), colorT'(v[3*i+1]), pixColor);
			checkDot($sformatf("%s px%0d dot", test, i), dotT'(v[3*i+2]), pixDot);
		end
	endtask

	////////////////////
	// Random cascade
	////////////////////

	// Layer 0 keeps reloading a row of dot 2, layer 1 stays empty
	task automatic randomCascade(string test, prioT layerPri, int count);
		prioT expPrio;
		colorT expColor;
		dotT expDot;
		loadLayer = 1'b0;
		loadRow = 12'h0f0;
		loadColor = 8'h77;
		loadValid = 1'b1;
		for (int c = 0; c < count + 16; c++) begin
			// Output now is the mix of the cascade driven one cycle ago
			if (c >= 16) begin
				checkPrio($sformatf("%s cyc%0d prio", test, c), expPrio, pixPrio);
				checkColor($sformatf("%s cyc%0d color", test, c), expColor, pixColor);
				checkDot($sformatf("%s cyc%0d dot", test, c), expDot, pixDot);
			end
			lcgState = lcgNext(lcgState);
			cascadePrio = lcgState[26:24];
			cascadeColor = lcgState[23:16];
			cascadeDot = lcgState[30:28];
			if (layerPri > cascadePrio) begin
				expPrio = layerPri;
				expColor = 8'h77;
				expDot = 3'd2;
			end else begin
				expPrio = cascadePrio;
				expColor = cascadeColor;
				expDot = cascadeDot;
			end
			@(posedge CLK_6M);
			#1;
		end
		loadValid = 1'b0;
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		arstN = 1'b0;
		{awvalid, wvalid, arvalid, loadValid} = '0;
		bready = 1'b1;
		rready = 1'b1;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		loadLayer = '0;
		loadRow = '0;
		loadColor = '0;
		cascadePrio = '0;
		cascadeColor = '0;
		cascadeDot = '0;
		lcgState = 32'hfafce292;
		fd = $fopen("tb/tileLayersVectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open tb/tileLayersVectors.txt");
			$display("SIMULATION FAILED");
			$fatal(1, "no vector file");
		end
		while ($fgets(text, fd) != 0) begin
			if (text.len() > 1 && text.getc(0) != "#") lines.push_back(text);
		end
		$fclose(fd);
		repeat (10) @(posedge CLK_6M);
		#1;
		arstN = 1'b1;
		foreach (lines[k]) begin
			void'($sscanf(lines[k], "%s", cmd));
			case (cmd)
				"W": begin
					void'($sscanf(lines[k], "%s %h %h %h", cmd, v[0], v[1], v[2]));
					busWrite(axiAddrT'(v[0]), v[1], axiRespT'(v[2]));
				end
				"R": begin
					void'($sscanf(lines[k], "%s %h %h %h", cmd, v[0], v[1], v[2]));
					busRead(axiAddrT'(v[0]), v[1], axiRespT'(v[2]));
				end
				"S": waitRowStart();
				"L": begin
					void'($sscanf(lines[k], "%s %h %h %h", cmd, v[0], v[1], v[2]));
					tileLoad(v[0][0], planeRowT'(v[1]), colorT'(v[2]));
				end
				"B": begin
					void'($sscanf(lines[k], "%s %h", cmd, v[0]));
					expectBusy(v[0][0]);
				end
				"C": begin
					void'($sscanf(lines[k], "%s %h %h %h", cmd, v[0], v[1], v[2]));
					cascadePrio = prioT'(v[0]);
					cascadeColor = colorT'(v[1]);
					cascadeDot = dotT'(v[2]);
					// Mixer takes the new cascade pixel at the next edge
					@(posedge CLK_6M);
					#1;
				end
				"P": begin
					void'($sscanf(lines[k], "%s %s %h %h %h %h %h %h %h %h %h %h %h %h",
						cmd, name, v[0], v[1], v[2], v[3], v[4], v[5],
						v[6], v[7], v[8], v[9], v[10], v[11]));
					expectRow(name);
				end
				"X": begin
					void'($sscanf(lines[k], "%s %s %h %h", cmd, name, v[0], v[1]));
					randomCascade(name, prioT'(v[0]), int'(v[1]));
				end
				default: begin
					$display("unknown vector command in line: %s", lines[k]);
					$display("SIMULATION FAILED");
					$fatal(1, "bad vector line");
				end
			endcase
		end
		$display("SIMULATION PASSED");
		$finish;
	end

	// Budget grows with the number of vector lines
	initial begin
		#1;
		repeat (50 * lines.size() + 200 + 10) @(posedge CLK_6M);
		$display("watchdog expired before the vector list finished");
		$display("SIMULATION FAILED");
		$fatal(1, "timeout");
	end

endmodule

// ==== tb/tileLayersVectors.txt ====
# W addr data resp | R addr expData resp | L layer row color | B layer | S = wait row start
# C prio color dot | P test (prio color dot) x4 | X test layer0Prio cycles, hex values
W 00 00000003 0
W 04 0000000A 0
R 00 00000003 0
R 04 0000000A 0
W 08 00000007 2
W 02 00000005 2
R 08 00000000 2
R 01 00000000 2
R 00 00000003 0
R 04 0000000A 0
S
L 0 358 21
P single 3 21 1 3 21 2 3 21 4 3 21 6
S
L 1 358 42
P flip 2 42 6 2 42 4 2 42 2 2 42 1
S
C 1 55 3
P passThrough 1 55 3 1 55 3 1 55 3 1 55 3
S
L 0 E6F A0
L 1 5E6 B1
P priority 3 A0 5 2 B1 3 1 55 3 3 A0 1
W 04 0000000B 0
C 2 66 0
S
L 0 358 21
L 1 358 42
P layerTie 3 21 1 3 21 2 3 21 4 3 21 6
C 3 66 0
S
L 0 358 21
L 1 358 42
P cascadeTie 3 66 0 3 66 0 3 66 0 3 66 0
C 0 00 0
S
L 0 358 21
B 0
L 0 E6F A0
P backPressure1 3 21 1 3 21 2 3 21 4 3 21 6
P backPressure2 3 A0 5 0 00 0 0 00 0 3 A0 1
X randomCascade 3 20
